// File: verilog/cpuPkg.sv
package cpuPkg;

    // Datapath word size. The packed types below are built on it.
    localparam int wordWidth = 32;

    // Strobe vectors in the control word are sized for the largest register file.
    localparam int maxRegs = 16;

    typedef logic [wordWidth-1:0] wordT;      // Bus and register word.
    typedef logic [2*wordWidth-1:0] dwordT;   // Full product held in Z.

    // ALU operation, taken from IR bits 31 to 27.
    typedef enum logic [4:0] {
        opInc  = 5'd0,   // Bus operand plus one, used for PC increment.
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShr  = 5'd7,
        opShra = 5'd8,
        opShl  = 5'd9,
        opRor  = 5'd10,
        opRol  = 5'd11,
        opMul  = 5'd15,  // Signed, result in Z high and Z low.
        opNeg  = 5'd17,
        opNot  = 5'd18
    } aluOpT;

    // All strobes for one microstep.
    typedef struct packed {
        logic [maxRegs-1:0] regIn;   // One load strobe per general register.
        logic [maxRegs-1:0] regOut;  // One bus drive strobe per general register.
        logic pcIn;
        logic pcOut;
        logic irIn;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic read;                  // MDR takes memory data instead of the bus.
        logic yIn;
        logic zIn;
        logic zLowOut;
        logic zHighOut;
        aluOpT aluOp;
    } ctrlT;

endpackage

// File: verilog/busMux.sv
`timescale 1ns/10ps
module busMux #(
    parameter int numRegs = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic [cpuPkg::maxRegs-1:0] regOut,
    input  cpuPkg::wordT regWords [numRegs],
    input  logic pcOut,
    input  cpuPkg::wordT pcData,
    input  logic mdrOut,
    input  cpuPkg::wordT mdrData,
    input  logic zLowOut,
    input  cpuPkg::wordT zLowData,
    input  logic zHighOut,
    input  cpuPkg::wordT zHighData,
    output cpuPkg::wordT busData
);
    import cpuPkg::*;

    localparam int idxW = (numRegs > 1) ? $clog2(numRegs) : 1;

    typedef enum logic [2:0] {srcNone, srcReg, srcPc, srcMdr, srcZLow, srcZHigh} srcT;

    srcT srcSel;
    logic [idxW-1:0] regIdx;
    logic [maxRegs+3:0] outStrobes;

    // Encode the one-hot strobes into a source select and register index.
    always_comb begin
        srcSel = srcNone;
        regIdx = '0;
        for (int i = 0; i < numRegs; i++) begin
            if (regOut[i]) begin
                srcSel = srcReg;
                regIdx = idxW'(i);
            end
        end
        if (pcOut) srcSel = srcPc;
        if (mdrOut) srcSel = srcMdr;
        if (zLowOut) srcSel = srcZLow;
        if (zHighOut) srcSel = srcZHigh;
    end

    always_comb begin
        case (srcSel)
            srcReg:   busData = regWords[regIdx];
            srcPc:    busData = pcData;
            srcMdr:   busData = mdrData;
            srcZLow:  busData = zLowData;
            srcZHigh: busData = zHighData;
            default:  busData = '0;  // Idle bus reads zero.
        endcase
    end

    assign outStrobes = {regOut, pcOut, mdrOut, zLowOut, zHighOut};

    // The sequencer must never enable two drivers in the same microstep.
    oneDriver: assert property (@(posedge clk) disable iff (!rstN) $onehot0(outStrobes))
        else $error("busMux: more than one source drives the bus (%b)", outStrobes);

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/10ps
module registerFile #(
    parameter int numRegs = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic [cpuPkg::maxRegs-1:0] regIn,
    input  cpuPkg::wordT busData,
    output cpuPkg::wordT regWords [numRegs]
);

    // General registers R0 to R(numRegs-1).
    // Strobe bits at or above numRegs have no register behind them.
    for (genvar r = 0; r < numRegs; r++) begin : gReg
        always_ff @(posedge clk) begin
            if (!rstN) begin
                regWords[r] <= '0;
            end else if (regIn[r]) begin
                regWords[r] <= busData;  // Load from the bus.
            end
        end
    end

endmodule

// File: verilog/memInterface.sv
`timescale 1ns/10ps
module memInterface (
    input  logic clk,
    input  logic rstN,
    input  logic marIn,
    input  logic mdrIn,
    input  logic read,
    input  cpuPkg::wordT busData,
    input  cpuPkg::wordT mDataIn,
    output cpuPkg::wordT marData,
    output cpuPkg::wordT mdrData
);
    import cpuPkg::*;

    wordT mdrNext;

    // Memory read data has the MDR input while read is high.
    assign mdrNext = read ? mDataIn : busData;

    // Address register, loaded only from the bus.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            marData <= '0;
        end else if (marIn) begin
            marData <= busData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mdrData <= '0;
        end else if (mdrIn) begin
            mdrData <= mdrNext;  // Memory or bus word.
        end
    end

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/10ps
module aluUnit (
    input  logic clk,
    input  logic rstN,
    input  logic yIn,
    input  logic zIn,
    input  cpuPkg::aluOpT aluOp,
    input  cpuPkg::wordT busData,
    output cpuPkg::wordT zLowData,
    output cpuPkg::wordT zHighData
);
    import cpuPkg::*;

    wordT yData;                  // Operand A.
    dwordT aluResult;
    dwordT zReg;
    logic [4:0] shAmt;
    logic [5:0] rotBack;
    logic signed [2*wordWidth-1:0] product;

    // Y holds the first operand while the second one sits on the bus.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            yData <= '0;
        end else if (yIn) begin
            yData <= busData;
        end
    end

    assign shAmt = busData[4:0];          // Shift amount from operand B.
    assign rotBack = 6'd32 - {1'b0, shAmt};

    // Both operands are signed, so the product is sign extended to 64 bits.
    assign product = $signed(yData) * $signed(busData);

    // Single word results go to Z low. Z high stays clear except for multiply.
    always_comb begin
        aluResult = '0;
        case (aluOp)
            opInc: begin
                aluResult[wordWidth-1:0] = busData + wordT'(1);
            end
            opAdd: begin
                aluResult[wordWidth-1:0] = yData + busData;
            end
            opSub: begin
                aluResult[wordWidth-1:0] = yData - busData;
            end
            opAnd: begin
                aluResult[wordWidth-1:0] = yData & busData;
            end
            opOr: begin
                aluResult[wordWidth-1:0] = yData | busData;
            end
            opShr: begin
                aluResult[wordWidth-1:0] = yData >> shAmt;
            end
            opShra: begin
                aluResult[wordWidth-1:0] = wordT'($signed(yData) >>> shAmt);
            end
            opShl: begin
                aluResult[wordWidth-1:0] = yData << shAmt;
            end
            opRor: begin
                // An amount of zero shifts the wrapped part fully out.
                aluResult[wordWidth-1:0] = (yData >> shAmt) | (yData << rotBack);
            end
            opRol: begin
                aluResult[wordWidth-1:0] = (yData << shAmt) | (yData >> rotBack);
            end
            opMul: begin
                aluResult = dwordT'(product);
            end
            opNeg: begin
                aluResult[wordWidth-1:0] = -busData;  // Unary ops act on operand B.
            end
            opNot: begin
                aluResult[wordWidth-1:0] = ~busData;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= aluResult;
        end
    end

    assign zLowData = zReg[wordWidth-1:0];
    assign zHighData = zReg[2*wordWidth-1:wordWidth];

    // The opcode comes from the IR field, so an unlisted encoding can reach the ALU.
    legalOp: assert property (@(posedge clk) disable iff (!rstN)
        zIn |-> aluOp inside {opInc, opAdd, opSub, opAnd, opOr, opShr, opShra,
                              opShl, opRor, opRol, opMul, opNeg, opNot})
        else $error("aluUnit: illegal opcode %0d loaded into Z", aluOp);

endmodule

// File: verilog/datapath.sv
`timescale 1ns/10ps
module datapath #(
    parameter int numRegs = 16
) (
    input  logic clk,
    input  logic rstN,
    input  cpuPkg::ctrlT ctrl,
    input  cpuPkg::wordT mDataIn,
    output cpuPkg::wordT busData,
    output cpuPkg::wordT pcData,
    output cpuPkg::wordT irData,
    output cpuPkg::wordT marData,
    output cpuPkg::wordT zLowData,
    output cpuPkg::wordT zHighData
);
    import cpuPkg::*;

    wordT regWords [numRegs];
    wordT mdrData;

    // Program counter. Increments go through the ALU and come back on the bus.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcData <= '0;
        end else if (ctrl.pcIn) begin
            pcData <= busData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            irData <= '0;
        end else if (ctrl.irIn) begin
            irData <= busData;  // Opcode sits in bits 31 to 27.
        end
    end

    busMux #(
        .numRegs(numRegs)
    ) uBusMux (
        .clk(clk),
        .rstN(rstN),
        .regOut(ctrl.regOut),
        .regWords(regWords),
        .pcOut(ctrl.pcOut),
        .pcData(pcData),
        .mdrOut(ctrl.mdrOut),
        .mdrData(mdrData),
        .zLowOut(ctrl.zLowOut),
        .zLowData(zLowData),
        .zHighOut(ctrl.zHighOut),
        .zHighData(zHighData),
        .busData(busData)
    );

    registerFile #(
        .numRegs(numRegs)
    ) uRegisterFile (
        .clk(clk),
        .rstN(rstN),
        .regIn(ctrl.regIn),
        .busData(busData),
        .regWords(regWords)
    );

    memInterface uMemInterface (
        .clk(clk),
        .rstN(rstN),
        .marIn(ctrl.marIn),
        .mdrIn(ctrl.mdrIn),
        .read(ctrl.read),
        .busData(busData),
        .mDataIn(mDataIn),
        .marData(marData),
        .mdrData(mdrData)
    );

    aluUnit uAluUnit (
        .clk(clk),
        .rstN(rstN),
        .yIn(ctrl.yIn),
        .zIn(ctrl.zIn),
        .aluOp(ctrl.aluOp),
        .busData(busData),
        .zLowData(zLowData),
        .zHighData(zHighData)
    );

    // A memory read is only meaningful in the cycle that MDR loads.
    readWithLoad: assert property (@(posedge clk) disable iff (!rstN) ctrl.read |-> ctrl.mdrIn)
        else $error("datapath: read strobe without mdrIn");

endmodule

// File: bench/datapathTb.sv
`timescale 1ns/10ps
module datapathTb;
    import cpuPkg::*;

    localparam int numRegs = 16;
    localparam int resetCycles = 10;
    localparam int cyclesPerCase = 12;     // Twelve microsteps per case.
    localparam int marginCycles = 200;
    localparam int randomPairs = 4;
    localparam string casesFile = "bench/datapathCases.txt";

    logic clk;
    logic rstN;
    ctrlT ctrl;
    wordT mDataIn;
    wordT busData;
    wordT pcData;
    wordT irData;
    wordT marData;
    wordT zLowData;
    wordT zHighData;

    // One entry per case, filled from the file and then from the random pairs.
    aluOpT caseOp [$];
    wordT caseA [$];
    wordT caseB [$];
    wordT caseLo [$];
    wordT caseHi [$];

    int errorCount = 0;
    int checkCount = 0;
    int numCases = 0;
    bit casesLoaded = 1'b0;
    wordT expPc;

    datapath #(
        .numRegs(numRegs)
    ) UUT (
        .clk(clk),
        .rstN(rstN),
        .ctrl(ctrl),
        .mDataIn(mDataIn),
        .busData(busData),
        .pcData(pcData),
        .irData(irData),
        .marData(marData),
        .zLowData(zLowData),
        .zHighData(zHighData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic checkWord(input string name, input wordT expected, input wordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkOp(input string name, input aluOpT expected, input aluOpT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[FAIL] %0t %s expected %s (%0d) actual %0d",
                     $time, name, expected.name(), expected, actual);
        end
    endtask

    task automatic loadCases();
        int fd;
        int got;
        string line;
        logic [4:0] opBits;
        wordT a;
        wordT b;
        wordT lo;
        wordT hi;
        fd = $fopen(casesFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the case file %s", casesFile);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", opBits, a, b, lo, hi) == 5) begin
                    caseOp.push_back(aluOpT'(opBits));
                    caseA.push_back(a);
                    caseB.push_back(b);
                    caseLo.push_back(lo);
                    caseHi.push_back(hi);
                end
            end
        end
        $fclose(fd);
        if (caseOp.size() == 0) begin
            errorCount++;
            $display("No cases were read from %s", casesFile);
        end
    endtask

    // Expected values follow the ALU rules. Add uses both operands, not uses B only.
    task automatic addRandomCases(input int count);
        wordT a;
        wordT b;
        for (int i = 0; i < count; i++) begin
            a = $urandom;
            b = $urandom;
            caseOp.push_back(opAdd);
            caseA.push_back(a);
            caseB.push_back(b);
            caseLo.push_back(a + b);
            caseHi.push_back('0);
            a = $urandom;
            b = $urandom;
            caseOp.push_back(opNot);
            caseA.push_back(a);
            caseB.push_back(b);
            caseLo.push_back(~b);
            caseHi.push_back('0);
        end
    endtask

    // One microstep. Returns mid cycle with the strobes still applied.
    task automatic microStep(input ctrlT c, input wordT mem);
        @(posedge clk);
        ctrl <= c;
        mDataIn <= mem;
        @(negedge clk);
    endtask

    task automatic idleStep();
        @(posedge clk);
        ctrl <= '0;
        mDataIn <= '0;
        @(negedge clk);
    endtask

    // Memory word into MDR, then MDR onto the bus toward the given destination.
    task automatic loadViaMdr(input wordT value, input ctrlT dest);
        ctrlT c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        microStep(c, value);
        c = dest;
        c.mdrOut = 1'b1;
        microStep(c, '0);
    endtask

    task automatic runCase(input int idx);
        ctrlT c;
        wordT instr;
        aluOpT op;
        op = caseOp[idx];
        instr = {op, 27'(idx)};      // Opcode in bits 31 to 27.
        c = '0;
        c.regIn[3] = 1'b1;
        loadViaMdr(caseA[idx], c);
        c = '0;
        c.regIn[5] = 1'b1;
        loadViaMdr(caseB[idx], c);
        c = '0;
        c.irIn = 1'b1;
        loadViaMdr(instr, c);
        c = '0;
        c.regOut[3] = 1'b1;
        c.yIn = 1'b1;
        microStep(c, '0);
        checkWord("busData (R3)", caseA[idx], busData);
        checkOp("irData[31:27]", op, aluOpT'(irData[31:27]));
        c = '0;
        c.regOut[5] = 1'b1;
        c.zIn = 1'b1;
        c.aluOp = aluOpT'(irData[31:27]);  // Decoded from IR as a sequencer would.
        microStep(c, '0);
        checkWord("busData (R5)", caseB[idx], busData);
        c = '0;
        c.zLowOut = 1'b1;
        c.regIn[1] = 1'b1;
        microStep(c, '0);
        checkWord("zLowData", caseLo[idx], zLowData);
        checkWord("zHighData", caseHi[idx], zHighData);
        c = '0;
        c.regOut[1] = 1'b1;
        microStep(c, '0);
        checkWord("busData (R1)", caseLo[idx], busData);
        c = '0;
        c.zHighOut = 1'b1;
        microStep(c, '0);
        checkWord("busData (Z high)", caseHi[idx], busData);
        idleStep();
    endtask

    // PC plus one through the ALU. MAR takes the old PC in the same step.
    task automatic stepPc();
        ctrlT c;
        c = '0;
        c.pcOut = 1'b1;
        c.marIn = 1'b1;
        c.zIn = 1'b1;
        c.aluOp = opInc;
        microStep(c, '0);
        checkWord("busData (PC)", expPc, busData);
        c = '0;
        c.zLowOut = 1'b1;
        c.pcIn = 1'b1;
        microStep(c, '0);
        checkWord("marData", expPc, marData);
        idleStep();
        expPc = expPc + 1;
        checkWord("pcData", expPc, pcData);
        checkWord("zHighData", '0, zHighData);
    endtask

    // Bus word into MDR with read low. Memory data differs so the source choice shows.
    task automatic busThroughMdr();
        ctrlT c;
        c = '0;
        c.pcOut = 1'b1;
        c.mdrIn = 1'b1;
        microStep(c, ~expPc);
        c = '0;
        c.mdrOut = 1'b1;
        microStep(c, '0);
        checkWord("busData (MDR)", expPc, busData);
        idleStep();
    endtask

    initial begin
        void'($urandom(63));
        rstN = 1'b0;
        ctrl = '0;
        mDataIn = '0;
        loadCases();
        addRandomCases(randomPairs);
        numCases = caseOp.size();
        casesLoaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkWord("busData", '0, busData);    // Everything cleared by reset.
        checkWord("pcData", '0, pcData);
        checkWord("irData", '0, irData);
        checkWord("zLowData", '0, zLowData);
        checkWord("zHighData", '0, zHighData);
        for (int i = 0; i < numCases; i++) begin
            runCase(i);
        end
        expPc = '0;
        repeat (3) stepPc();
        busThroughMdr();
        $display("Cases run: %0d, checks: %0d, errors: %0d", numCases, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog sized from the number of cases once the file is read.
    initial begin
        longint limitCycles;
        wait (casesLoaded);
        limitCycles = longint'(numCases) * cyclesPerCase + resetCycles + marginCycles;
        #(limitCycles * 10);
        $display("Timeout: the run did not finish within %0d cycles", limitCycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/datapathCases.txt
# Columns: opcode, operand A (Y), operand B (bus), expected Z low, expected Z high.
# All values are hex. Shifts and rotates use the low 5 bits of B, neg and not act on B.
03 00000005 00000007 0000000C 00000000
03 FFFFFFFF 00000001 00000000 00000000
04 00000010 00000003 0000000D 00000000
04 00000003 00000010 FFFFFFF3 00000000
05 F0F0F0F0 0FF00FF0 00F000F0 00000000
06 F0F0F0F0 0FF00FF0 FFF0FFF0 00000000
06 00000000 00000000 00000000 00000000
07 8000FA92 0000000A 0020003E 00000000
07 FFFFFFFF 0000001F 00000001 00000000
08 8000FA92 0000000A FFE0003E 00000000
08 7FFFFFFF 0000001F 00000000 00000000
09 8000FA92 0000000A 03EA4800 00000000
09 00000001 FFFFFF24 00000010 00000000
0A 8000FA92 0000000A A4A0003E 00000000
0A 12345678 00000000 12345678 00000000
0A 00000001 00000001 80000000 00000000
0B 8000FA92 0000000A 03EA4A00 00000000
0B 80000001 00000001 00000003 00000000
0F 00000003 00000005 0000000F 00000000
0F FFFFFFFE 00000003 FFFFFFFA FFFFFFFF
0F 00010000 00010000 00000000 00000001
0F 80000000 80000000 00000000 40000000
0F 7FFFFFFF FFFFFFFF 80000001 FFFFFFFF
11 00000000 00000001 FFFFFFFF 00000000
11 00000000 80000000 80000000 00000000
12 12345678 0F0F0F0F F0F0F0F0 00000000
00 00000000 FFFFFFFF 00000000 00000000
00 00000000 0000002A 0000002B 00000000

// File: build.f
verilog/cpuPkg.sv
verilog/busMux.sv
verilog/registerFile.sv
verilog/memInterface.sv
verilog/aluUnit.sv
verilog/datapath.sv
bench/datapathTb.sv

// File: run.sh
#!/bin/sh
# Build the datapath testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f build.f --top-module datapathTb -o datapathSim || exit 1

./obj_dir/datapathSim > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && echo "FAIL" && exit 1
grep -q "Simulation completed successfully" sim.log && echo "PASS" && exit 0
echo "FAIL: no result in sim.log" || true
exit 1
